// ==== common/lsu_defines.svh ====
// width macros for the data path and the data ram index
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// core data width, rv64
`define LSU_XLEN 64

// doubleword index width of the data ram
// 8 bits -> 256 doublewords, 2 KiB
// also the length of the zero-fill sweep
`define LSU_DMEM_AW 8

`endif

// ==== common/lsu_op_pkg.sv ====
// memory op encoding and the core-side request struct
`include "lsu_defines.svh"

package lsu_op_pkg;

  // same encoding as the decode stage hands out
  typedef enum logic [2:0] {
    MEM_SB   = 3'd0, // signed byte
    MEM_UB   = 3'd1, // unsigned byte
    MEM_SH   = 3'd2, // signed half
    MEM_UH   = 3'd3, // unsigned half
    MEM_SW   = 3'd4, // signed word
    MEM_UW   = 3'd5, // unsigned word
    MEM_D    = 3'd6, // doubleword
    MEM_NONE = 3'd7  // no access
  } mem_op_e;

  // one access from the core valid with the strobe
  typedef struct packed {
    mem_op_e                op;
    logic                   we;    // 1 = store
    logic [`LSU_XLEN-1:0]   addr;  // byte address
    logic [`LSU_XLEN-1:0]   wdata; // store data lsb aligned
  } lsu_req_t;

endpackage

// ==== common/lsu_mem_pkg.sv ====
// ram beat struct, doubleword union and access size helper
`include "lsu_defines.svh"

package lsu_mem_pkg;

  import lsu_op_pkg::*;

  // one doubleword access to the data ram
  typedef struct packed {
    logic                     en;     // access this cycle
    logic                     we;     // write, else read
    logic [`LSU_DMEM_AW-1:0]  idx;    // doubleword index
    logic [7:0]               mask;   // byte write enables
    logic [`LSU_XLEN-1:0]     data;   // lane aligned write data
    logic                     second; // upper beat of a split access
  } beat_t;

  // one doubleword seen by lane
  typedef union packed {
    logic [`LSU_XLEN/8-1:0][7:0]   b; // bytes
    logic [`LSU_XLEN/16-1:0][15:0] h; // halfwords
    logic [`LSU_XLEN/32-1:0][31:0] w; // words
  } dword_u;

  // bytes touched by an op and 0 for none
  function automatic logic [3:0] op_bytes(mem_op_e op);
    case (op)
      MEM_SB, MEM_UB: op_bytes = 4'd1;
      MEM_SH, MEM_UH: op_bytes = 4'd2;
      MEM_SW, MEM_UW: op_bytes = 4'd4;
      MEM_D:          op_bytes = 4'd8;
      default:        op_bytes = 4'd0;
    endcase
  endfunction

endpackage

// ==== hdl/clear_sweep_counter.sv ====
// index counter for the post-reset zero-fill of the data ram
`timescale 1ns/1ns
`include "lsu_defines.svh"

module clear_sweep_counter (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_en,
  output logic [`LSU_DMEM_AW-1:0] o_idx,
  output logic                    o_last
);

  logic [`LSU_DMEM_AW-1:0] idx_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      idx_q <= '0; // sweep restarts at index 0
    end else if (i_en) begin
      idx_q <= idx_q + 1'b1; // wraps back to 0 after the top
    end
  end

  assign o_idx  = idx_q;
  assign o_last = i_en && (idx_q == '1); // top index this cycle

endmodule

// ==== hdl/dmem_sram.sv ====
// byte write enabled synchronous doubleword ram
`timescale 1ns/1ns
`include "lsu_defines.svh"

module dmem_sram (
  input  logic                 i_clk,
  input  lsu_mem_pkg::beat_t   i_beat,
  output logic [`LSU_XLEN-1:0] o_rdata
);

  logic [`LSU_XLEN-1:0] mem [0:(1 << `LSU_DMEM_AW)-1];

  always_ff @(posedge i_clk) begin
    if (i_beat.en) begin
      o_rdata <= mem[i_beat.idx]; // read-first so old contents come out
      if (i_beat.we) begin
        for (int b = 0; b < 8; b++) begin
          if (i_beat.mask[b]) mem[i_beat.idx][b*8 +: 8] <= i_beat.data[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== lsu/lsu_ctrl.sv ====
// access sequencer fsm for post-reset clear, single beat and split two-beat accesses
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_ctrl (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_req_stb,
  input  lsu_op_pkg::lsu_req_t    i_req,
  input  logic                    i_sweep_last,
  input  logic [`LSU_DMEM_AW-1:0] i_sweep_idx,
  output logic                    o_sweep_en,
  output logic                    o_beat_en,
  output logic                    o_beat_we,
  output logic [`LSU_DMEM_AW-1:0] o_beat_idx,
  output logic                    o_beat_second,
  output lsu_op_pkg::lsu_req_t    o_req_q,
  output logic                    o_busy,
  output logic                    o_cap_low,
  output logic                    o_finish
);

  import lsu_op_pkg::*;
  import lsu_mem_pkg::*;

  typedef enum logic [1:0] {ST_CLEAR, ST_IDLE, ST_SPLIT} state_e;

  state_e   state_q;
  lsu_req_t req_q;      // latched request
  logic     issue_q;    // a beat from req_q is due
  logic     second_q;   // ... and it is the upper one
  logic     cap_low_q, finish_q;
  logic     accept;
  logic [3:0] span;     // offset + size, up to 15
  logic     crosses;

  assign accept  = (state_q == ST_IDLE) && i_req_stb && (i_req.op != MEM_NONE);
  assign span    = {1'b0, i_req.addr[2:0]} + op_bytes(i_req.op);
  assign crosses = span > 4'd8; // last byte lands in next dword

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      state_q   <= ST_CLEAR;
      issue_q   <= 1'b0;
      second_q  <= 1'b0;
      cap_low_q <= 1'b0;
      finish_q  <= 1'b0;
    end else begin
      // pulses trail the ram read by one cycle
      cap_low_q <= o_beat_en && !o_beat_we && (state_q == ST_SPLIT);
      finish_q  <= o_beat_en && (state_q == ST_IDLE); // last beat of a store or load
      issue_q   <= 1'b0;
      second_q  <= 1'b0;
      case (state_q)
        ST_CLEAR: if (i_sweep_last) state_q <= ST_IDLE;
        ST_IDLE: begin
          if (accept) begin
            issue_q <= !crosses;
            if (crosses) state_q <= ST_SPLIT; // low beat next cycle
          end
        end
        ST_SPLIT: begin
          state_q  <= ST_IDLE;  // upper beat goes out from idle
          issue_q  <= 1'b1;
          second_q <= 1'b1;
        end
        default: state_q <= ST_CLEAR;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) req_q <= i_req;
  end

  always_comb begin
    o_beat_en     = 1'b0;
    o_beat_we     = req_q.we;
    o_beat_idx    = req_q.addr[3 +: `LSU_DMEM_AW];
    o_beat_second = 1'b0;
    case (state_q)
      ST_CLEAR: begin
        o_beat_en  = 1'b1;
        o_beat_we  = 1'b1;        // zero write
        o_beat_idx = i_sweep_idx;
      end
      ST_SPLIT: o_beat_en = 1'b1; // lower dword
      default: begin
        o_beat_en     = issue_q;
        o_beat_second = second_q;
        if (second_q) o_beat_idx = req_q.addr[3 +: `LSU_DMEM_AW] + 1'b1;
      end
    endcase
  end

  assign o_sweep_en = (state_q == ST_CLEAR);
  assign o_busy     = (state_q != ST_IDLE); // clear or first split beat
  assign o_req_q    = req_q;
  assign o_cap_low  = cap_low_q;
  assign o_finish   = finish_q;

endmodule

// ==== lsu/store_lane_align.sv ====
// byte mask and lane shifted write data for one ram beat
`timescale 1ns/1ns
`include "lsu_defines.svh"

module store_lane_align (
  input  logic                    i_en,
  input  logic                    i_we,
  input  logic [`LSU_DMEM_AW-1:0] i_idx,
  input  logic                    i_second,
  input  logic                    i_clear,
  input  lsu_op_pkg::lsu_req_t    i_req,
  output lsu_mem_pkg::beat_t      o_beat
);

  import lsu_mem_pkg::*;

  logic [2:0]       off;       // byte offset in dword
  logic [7:0]       size_mask; // lsb aligned
  logic [15:0]      mask_win;  // two dword window
  logic [15:0][7:0] data_win;
  dword_u           src;

  always_comb begin
    off = i_req.addr[2:0];
    src = i_req.wdata;
    case (op_bytes(i_req.op))
      4'd1:    size_mask = 8'h01;
      4'd2:    size_mask = 8'h03;
      4'd4:    size_mask = 8'h0f;
      4'd8:    size_mask = 8'hff;
      default: size_mask = 8'h00; // none writes nothing
    endcase
    mask_win = {8'h00, size_mask} << off;
    data_win = '0;
    for (int j = 0; j < 8; j++) begin
      data_win[off + j] = src.b[j]; // spill past lane 7 goes high
    end
  end

  always_comb begin
    o_beat.en     = i_en;
    o_beat.we     = i_we;
    o_beat.idx    = i_idx;
    o_beat.second = i_second;
    if (i_clear) begin
      o_beat.mask = 8'hff;
      o_beat.data = '0;
    end else begin
      o_beat.mask = i_second ? mask_win[15:8] : mask_win[7:0];
      o_beat.data = i_second ? data_win[15:8] : data_win[7:0];
    end
  end

endmodule

// ==== lsu/load_extend.sv ====
// split beat merge, lane select and sign or zero extension of load data
`timescale 1ns/1ns
`include "lsu_defines.svh"

module load_extend (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [`LSU_XLEN-1:0]  i_rdata,
  input  logic                  i_cap_low,
  input  logic                  i_finish,
  input  lsu_op_pkg::lsu_req_t  i_req,
  output logic                  o_load_stb,
  output logic [`LSU_XLEN-1:0]  o_load_data
);

  import lsu_op_pkg::*;
  import lsu_mem_pkg::*;

  lsu_req_t             req_d;  // request of the data now on i_rdata
  logic [`LSU_XLEN-1:0] low_q;  // lower dword of a split load
  logic [15:0][7:0]     win;
  logic [2:0]           off;
  logic                 split;
  dword_u               sel;    // addressed bytes at lane 0
  logic [`LSU_XLEN-1:0] ext;

  always_ff @(posedge i_clk) begin
    req_d <= i_req;               // follows the ram read by a cycle
    if (i_cap_low) low_q <= i_rdata;
  end

  always_comb begin
    off   = req_d.addr[2:0];
    split = ({1'b0, off} + op_bytes(req_d.op)) > 4'd8;
    win   = split ? {i_rdata, low_q} : {i_rdata, i_rdata};
    for (int i = 0; i < 8; i++) begin
      sel.b[i] = win[off + i];
    end
    case (req_d.op)
      MEM_SB:  ext = {{56{sel.b[0][7]}}, sel.b[0]};
      MEM_UB:  ext = {56'd0, sel.b[0]};
      MEM_SH:  ext = {{48{sel.h[0][15]}}, sel.h[0]};
      MEM_UH:  ext = {48'd0, sel.h[0]};
      MEM_SW:  ext = {{32{sel.w[0][31]}}, sel.w[0]};
      MEM_UW:  ext = {32'd0, sel.w[0]};
      default: ext = sel;         // doubleword
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      o_load_stb <= 1'b0;
    end else begin
      o_load_stb <= i_finish && !req_d.we; // stores end silently
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_finish && !req_d.we) o_load_data <= ext;
  end

endmodule

// ==== hdl/lsu_top.sv ====
// load/store unit top with sequencer, sweep counter, lane aligners and data ram
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_top (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_req_stb,
  input  lsu_op_pkg::lsu_req_t  i_req,
  output logic                  o_busy,
  output logic                  o_load_stb,
  output logic [`LSU_XLEN-1:0]  o_load_data
);

  import lsu_op_pkg::*;
  import lsu_mem_pkg::*;

  lsu_req_t                req_q;      // request at beat issue
  beat_t                   beat;       // to the ram
  logic [`LSU_XLEN-1:0]    rdata;      // registered ram read
  logic                    sweep_en;
  logic                    sweep_last;
  logic [`LSU_DMEM_AW-1:0] sweep_idx;
  logic                    beat_en, beat_we, beat_second;
  logic [`LSU_DMEM_AW-1:0] beat_idx;
  logic                    cap_low, finish;

  lsu_ctrl u_ctrl (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_req_stb     (i_req_stb),
    .i_req         (i_req),
    .i_sweep_last  (sweep_last),
    .i_sweep_idx   (sweep_idx),
    .o_sweep_en    (sweep_en),
    .o_beat_en     (beat_en),
    .o_beat_we     (beat_we),
    .o_beat_idx    (beat_idx),
    .o_beat_second (beat_second),
    .o_req_q       (req_q),
    .o_busy        (o_busy),
    .o_cap_low     (cap_low),
    .o_finish      (finish)
  );

  clear_sweep_counter u_sweep (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_en   (sweep_en),
    .o_idx  (sweep_idx),
    .o_last (sweep_last)
  );

  store_lane_align u_store (
    .i_en     (beat_en),
    .i_we     (beat_we),
    .i_idx    (beat_idx),
    .i_second (beat_second),
    .i_clear  (sweep_en), // zero-fill while sweeping
    .i_req    (req_q),
    .o_beat   (beat)
  );

  dmem_sram u_ram (
    .i_clk   (i_clk),
    .i_beat  (beat),
    .o_rdata (rdata)
  );

  load_extend u_load (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rdata     (rdata),
    .i_cap_low   (cap_low),
    .i_finish    (finish),
    .i_req       (req_q),
    .o_load_stb  (o_load_stb),
    .o_load_data (o_load_data)
  );

endmodule

// ==== tb/lsu_tb.sv ====
// directed testbench for lsu_top with byte reference model, test tasks and watchdog
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_tb;
  import lsu_op_pkg::*;

  localparam int CLK_NS       = 4;
  localparam int RESET_CYCLES = 16;
  localparam int SWEEP_CYCLES = 1 << `LSU_DMEM_AW;
  localparam int ADDR_BITS    = `LSU_DMEM_AW + 3;  // byte address bits inside the ram
  localparam int MEM_BYTES    = 1 << ADDR_BITS;
  localparam int LOAD_WAIT    = 8;                 // cycles before a load counts as lost
  localparam int ACCESSES     = 120;               // accesses over all tests
  localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + SWEEP_CYCLES + ACCESSES * LOAD_WAIT) * CLK_NS;

  logic clk, rst, req_stb, busy, load_stb;
  lsu_req_t req;
  logic [`LSU_XLEN-1:0] load_data;
  logic [7:0] ref_mem [0:MEM_BYTES-1];  // expected ram bytes
  logic [31:0] rng_state = 32'hd22b_693f;
  string cur_test;
  int test_errors, errors, checks, tests_run, tests_failed;

  lsu_top u_dut (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_req_stb   (req_stb),
    .i_req       (req),
    .o_busy      (busy),
    .o_load_stb  (load_stb),
    .o_load_data (load_data)
  );

  always #(CLK_NS / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [63:0] rand_dword();
    logic [31:0] hi, lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  // byte address inside the ram aligned to align bytes
  function automatic logic [63:0] rand_addr(int align);
    return 64'(next_rand() & (MEM_BYTES - 1)) & ~64'(align - 1);
  endfunction

  function automatic int access_size(mem_op_e op);
    case (op)
      MEM_SB, MEM_UB: return 1;
      MEM_SH, MEM_UH: return 2;
      MEM_SW, MEM_UW: return 4;
      MEM_D:          return 8;
      default:        return 0;
    endcase
  endfunction

  // last byte beyond the addressed doubleword
  function automatic bit crosses(mem_op_e op, logic [63:0] addr);
    return int'(addr[2:0]) + access_size(op) > 8;
  endfunction

  function automatic void model_store(mem_op_e op, logic [63:0] addr, logic [63:0] data);
    logic [63:0] a;
    for (int i = 0; i < access_size(op); i++) begin
      a = addr + i;  // wraps at the top of the ram
      ref_mem[a[ADDR_BITS-1:0]] = data[8*i +: 8];
    end
  endfunction

  function automatic logic [63:0] model_load(mem_op_e op, logic [63:0] addr);
    logic [63:0] a, v;
    int n;
    n = access_size(op);
    v = '0;
    for (int i = 0; i < n; i++) begin
      a = addr + i;
      v[8*i +: 8] = ref_mem[a[ADDR_BITS-1:0]];
    end
    // signed ops copy the top loaded bit upward
    if ((op == MEM_SB || op == MEM_SH || op == MEM_SW) && v[8*n-1]) begin
      for (int i = 8 * n; i < 64; i++) v[i] = 1'b1;
    end
    return v;
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #1;  // drive and sample point
  endtask

  task automatic report_failure(input string line);
    test_errors++;
    errors++;
    $display("%s", line);
  endtask

  task automatic check_load_data(input string what, input logic [`LSU_XLEN-1:0] exp, act);
    checks++;
    if (act !== exp)
      report_failure($sformatf("[ERROR] %s, %s: expected %h, actual %h", cur_test, what, exp, act));
  endtask

  task automatic expect_busy(input string what, input logic exp, act);
    checks++;
    if (act !== exp)
      report_failure($sformatf("[ERROR] %s, %s: o_busy expected %b, actual %b",
                               cur_test, what, exp, act));
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("test %-16s %s (%0d errors)", cur_test, test_errors ? "failed" : "ok", test_errors);
  endtask

  // one-cycle strobe once the unit is free
  task automatic issue_request(mem_op_e op, logic we, logic [63:0] addr, logic [63:0] wdata);
    int n = 0;
    while (busy !== 1'b0 && n < LOAD_WAIT) begin
      step_cycle();
      n++;
    end
    if (busy !== 1'b0) report_failure($sformatf("%s: o_busy stuck high before a request", cur_test));
    req.op    = op;
    req.we    = we;
    req.addr  = addr;
    req.wdata = wdata;
    req_stb   = 1'b1;
    step_cycle();
    req_stb   = 1'b0;
  endtask

  task automatic store_access(input string what, mem_op_e op, logic [63:0] addr, logic [63:0] d);
    issue_request(op, 1'b1, addr, d);
    model_store(op, addr, d);
    expect_busy(what, crosses(op, addr), busy);  // high one cycle only when split
    if (crosses(op, addr)) begin
      step_cycle();
      expect_busy(what, 1'b0, busy);
    end
  endtask

  task automatic load_access(input string what, mem_op_e op, logic [63:0] addr);
    logic [63:0] exp;
    int lat, k;
    exp = model_load(op, addr);
    lat = crosses(op, addr) ? 3 : 2;  // edges from the strobe edge
    k   = 0;
    issue_request(op, 1'b0, addr, rand_dword());  // store data ignored
    expect_busy(what, crosses(op, addr), busy);
    while (load_stb !== 1'b1 && k < LOAD_WAIT) begin
      step_cycle();
      k++;
      if (k == 1) expect_busy(what, 1'b0, busy);
    end
    if (load_stb !== 1'b1) begin
      report_failure($sformatf("%s, %s: no load result within %0d cycles", cur_test, what, k));
    end else begin
      if (k != lat)
        report_failure($sformatf("%s, %s: load result after %0d cycles instead of %0d",
                                 cur_test, what, k, lat));
      check_load_data(what, exp, load_data);
    end
  endtask

  task automatic reset_and_sweep();
    int n;
    start_test("reset_sweep");
    rst = 1'b0;
    repeat (RESET_CYCLES) begin
      step_cycle();
      if (load_stb !== 1'b0) report_failure($sformatf("%s: load strobe during reset", cur_test));
    end
    rst = 1'b1;
    n = 0;
    while (busy === 1'b1 && n <= SWEEP_CYCLES) begin  // zero-fill cycles
      n++;
      step_cycle();
      if (load_stb !== 1'b0)
        report_failure($sformatf("%s: load strobe during the zero-fill", cur_test));
    end
    checks++;
    if (n != SWEEP_CYCLES)
      report_failure($sformatf("[ERROR] %s: busy cycles after reset expected %0d, actual %0d",
                               cur_test, SWEEP_CYCLES, n));
    for (int i = 0; i < 16; i++)
      load_access($sformatf("zero load %0d", i), mem_op_e'(next_rand() % 7), rand_addr(1));
    finish_test();
  endtask

  task automatic aligned_ops();
    logic [63:0] a, d;
    int n;
    start_test("aligned_ops");
    for (int r = 0; r < 2; r++) begin
      for (int o = 0; o < 7; o++) begin
        n = access_size(mem_op_e'(o));
        a = rand_addr(n);
        d = rand_dword();
        d[8*n-1] = (r == 0);  // both signs of the loaded top bit
        store_access($sformatf("store op%0d", o), mem_op_e'(o), a, d);
        load_access($sformatf("load op%0d", o), mem_op_e'(o), a);
      end
    end
    finish_test();
  endtask

  task automatic mask_isolation();
    logic [63:0] base;
    start_test("mask_isolation");
    base = rand_addr(8);
    store_access("fill", MEM_D, base, rand_dword());
    for (int l = 0; l < 8; l++) begin
      store_access($sformatf("byte lane %0d", l), l[0] ? MEM_UB : MEM_SB, base + l, rand_dword());
      load_access($sformatf("dword after byte %0d", l), MEM_D, base);
    end
    for (int l = 0; l < 8; l += 2) begin
      store_access($sformatf("half lane %0d", l), MEM_SH, base + l, rand_dword());
      load_access($sformatf("dword after half %0d", l), MEM_D, base);
    end
    finish_test();
  endtask

  task automatic split_accesses();
    logic [63:0] a;
    start_test("split_accesses");
    for (int off = 5; off < 8; off++) begin
      a = rand_addr(8) + off;
      store_access($sformatf("word store +%0d", off), MEM_SW, a, rand_dword());
      load_access($sformatf("signed word +%0d", off), MEM_SW, a);
      load_access($sformatf("unsigned word +%0d", off), MEM_UW, a);
      load_access("low neighbor", MEM_D, a - off);  // bytes around the split
      load_access("high neighbor", MEM_D, a - off + 8);
    end
    for (int off = 1; off < 8; off++) begin
      a = rand_addr(8) + off;
      store_access($sformatf("dword store +%0d", off), MEM_D, a, rand_dword());
      load_access($sformatf("dword load +%0d", off), MEM_D, a);
    end
    a = MEM_BYTES - 3;  // upper beat wraps to index 0
    store_access("wrap store", MEM_D, a, rand_dword());
    load_access("wrap load", MEM_D, a);
    load_access("index 0", MEM_D, 64'd0);
    finish_test();
  endtask

  task automatic burst_and_none();
    logic [63:0] base, a;
    logic [63:0] exp_q[$];
    int due_q[$];
    mem_op_e op;
    int c, issued, got;
    start_test("burst_and_none");
    base = rand_addr(8);
    for (int i = 0; i < 8; i++)
      store_access($sformatf("fill %0d", i), MEM_D, base + 8 * i, rand_dword());
    c = 0;
    issued = 0;
    got = 0;
    while ((issued < 8 || exp_q.size() != 0) && c < 8 + LOAD_WAIT) begin
      req_stb = 1'b0;
      if (issued < 8) begin  // a new load every cycle
        op = mem_op_e'(issued % 7);
        a  = base + 8 * issued + (issued % (8 / access_size(op))) * access_size(op);
        expect_busy($sformatf("burst issue %0d", issued), 1'b0, busy);
        req.op   = op;
        req.we   = 1'b0;
        req.addr = a;
        req_stb  = 1'b1;
        exp_q.push_back(model_load(op, a));
        due_q.push_back(c + 3);  // sampled next edge and result two later
        issued++;
      end
      step_cycle();
      c++;
      if (load_stb === 1'b1) begin
        if (exp_q.size() == 0) begin
          report_failure($sformatf("%s: load strobe with no load outstanding", cur_test));
        end else begin
          if (due_q.pop_front() != c)
            report_failure($sformatf("%s: burst load %0d out of step", cur_test, got));
          check_load_data($sformatf("burst load %0d", got), exp_q.pop_front(), load_data);
          got++;
        end
      end
    end
    req_stb = 1'b0;
    if (exp_q.size() != 0)
      report_failure($sformatf("%s: %0d burst loads never returned", cur_test, exp_q.size()));
    issue_request(MEM_NONE, 1'b1, base, rand_dword());  // must not write
    issue_request(MEM_NONE, 1'b0, base + 3, 64'd0);
    repeat (4) begin
      if (load_stb === 1'b1) report_failure($sformatf("%s: op none gave a load strobe", cur_test));
      step_cycle();
    end
    load_access("dword after none", MEM_D, base);
    finish_test();
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b0;
    req_stb   = 1'b0;
    req.op    = MEM_NONE;
    req.we    = 1'b0;
    req.addr  = '0;
    req.wdata = '0;
    for (int i = 0; i < MEM_BYTES; i++) ref_mem[i] = 8'h00;  // ram after the sweep
    reset_and_sweep();
    aligned_ops();
    mask_isolation();
    split_accesses();
    burst_and_none();
    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+common
common/lsu_op_pkg.sv
common/lsu_mem_pkg.sv
hdl/clear_sweep_counter.sv
hdl/dmem_sram.sv
lsu/lsu_ctrl.sv
lsu/store_lane_align.sv
lsu/load_extend.sv
hdl/lsu_top.sv
tb/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

export_include_dirs:
  - common

sources:
  - common/lsu_op_pkg.sv
  - common/lsu_mem_pkg.sv
  - hdl/clear_sweep_counter.sv
  - hdl/dmem_sram.sv
  - lsu/lsu_ctrl.sv
  - lsu/store_lane_align.sv
  - lsu/load_extend.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - tb/lsu_tb.sv
